// File: test/udp_rx_vectors.txt
// Tagged words of three hex digits. Tag 0 input byte, 1 input byte with last,
// 4 src_mac byte, 5 src_ip byte, 6 src_port byte, 7 dest_port byte, 8 payload, 9 payload last
// Valid UDP frame A, 4 byte payload
002 000 000 000 000 001 002 011 022 033 044 055 008 000 045 000 000 020 000 001 000 000 040 011
000 000 0C0 0A8 001 00A 0C0 0A8 001 001 004 0D2 016 02E 000 00C 000 000 0DE 0AD 0BE 1EF
// EtherType 86DD, dropped
002 000 000 000 000 001 002 0AA 0BB 0CC 0DD 0EE 086 0DD 045 000 000 01E 000 002 000 000 040 011
000 000 0C0 0A8 001 00D 0C0 0A8 001 001 004 0D2 016 02E 000 00A 000 000 055 166
// IP protocol 6, dropped
002 000 000 000 000 001 002 011 022 033 044 066 008 000 045 000 000 01E 000 003 000 000 040 006
000 000 0C0 0A8 001 00B 0C0 0A8 001 001 004 0D2 016 02E 000 00A 000 000 077 188
// Valid UDP frame B, 3 byte payload
002 000 000 000 000 001 002 066 077 088 099 0AA 008 000 045 000 000 01F 000 004 000 000 040 011
000 000 00A 000 000 005 0C0 0A8 001 001 01F 090 000 035 000 00B 000 000 011 022 133
// IHL 6 with four option bytes, dropped
002 000 000 000 000 001 002 011 022 033 044 077 008 000 046 000 000 022 000 005 000 000 040 011
000 000 0C0 0A8 001 00C 0C0 0A8 001 001 001 001 001 001 004 0D2 016 02E 000 00A 000 000 099 1AA
// IP version 6, dropped
002 000 000 000 000 001 002 011 022 033 044 088 008 000 065 000 000 01E 000 006 000 000 040 011
000 000 0C0 0A8 001 00D 0C0 0A8 001 001 004 0D2 016 02E 000 00A 000 000 0BB 1CC
// Ends inside the Ethernet header
002 000 000 000 000 001 002 011 122
// Ends inside the IP header
002 000 000 000 000 001 002 011 022 033 044 099 008 000 045 000 000 01E 000 007 000 000 040 111
// Ends on the last UDP header byte, empty payload
002 000 000 000 000 001 002 011 022 033 044 0AA 008 000 045 000 000 01C 000 008 000 000 040 011
000 000 0C0 0A8 001 00E 0C0 0A8 001 001 004 0D2 016 02E 000 008 000 100
// Valid UDP frame C, 1 byte payload
002 000 000 000 000 001 002 0C0 0FF 0EE 000 001 008 000 045 000 000 01D 000 009 000 000 040 011
000 000 0AC 010 000 002 0C0 0A8 001 001 0C3 050 000 007 000 009 000 000 15A
// Valid UDP frame D, 5 byte payload
002 000 000 000 000 001 002 012 034 056 078 09A 008 000 045 000 000 021 000 00A 000 000 040 011
000 000 00A 001 002 003 0C0 0A8 001 001 030 039 0D4 031 000 00D 000 000 001 002 003 004 105
// Expected frames A, B, C and D
402 411 422 433 444 455 5C0 5A8 501 50A 604 6D2 716 72E 8DE 8AD 8BE 9EF
402 466 477 488 499 4AA 50A 500 500 505 61F 690 700 735 811 822 933
402 4C0 4FF 4EE 400 401 5AC 510 500 502 6C3 650 700 707 95A
402 412 434 456 478 49A 50A 501 502 503 630 639 7D4 731 801 802 803 804 905
FFF

// File: sources.f
common/udp_rx_pkg.sv
hw/eth_hdr_rx.sv
hw/ip_hdr_rx.sv
hw/udp_hdr_rx.sv
hw/udp_rx_top.sv
test/tb_udp_rx.sv

// File: Bender.yml
package:
  name: udp_rx

sources:
  - files:
      - common/udp_rx_pkg.sv
      - hw/eth_hdr_rx.sv
      - hw/ip_hdr_rx.sv
      - hw/udp_hdr_rx.sv
      - hw/udp_rx_top.sv
  - target: test
    files:
      - test/tb_udp_rx.sv

// File: test/tb_udp_rx.sv
`default_nettype none

// Testbench for the UDP receive path driven by frames from a vector file
module tb_udp_rx
    import udp_rx_pkg::*;
();

    logic              clk = 1'b0;
    logic              rst_n;
    logic [DATA_W-1:0] s_data;
    logic              s_valid;
    logic              s_last;
    logic              m_ready;
    wire               s_ready;
    wire  [DATA_W-1:0] m_data;
    wire               m_valid;
    wire               m_last;
    wire  [MAC_W-1:0]  src_mac;
    wire  [IP_W-1:0]   src_ip;
    wire  [PORT_W-1:0] src_port;
    wire  [PORT_W-1:0] dest_port;

    // Vector words with the tag in the top nibble
    logic [11:0]       vec_mem [0:1023];
    // Bytes with the last flag on top
    logic [DATA_W:0]   in_bytes [$];
    logic [DATA_W:0]   exp_pay [$];
    logic [MAC_W-1:0]  exp_mac [$];
    logic [IP_W-1:0]   exp_ip [$];
    logic [PORT_W-1:0] exp_sport [$];
    logic [PORT_W-1:0] exp_dport [$];

    int          pay_total = 0;
    int          pay_pos = 0;
    int          frames_seen = 0;
    int          value_errors = 0;
    int          frame_errors = 0;
    logic        vectors_ready = 1'b0;
    logic [31:0] rng_state = 32'd76750;
    logic        send_ok;

    always #2 clk = ~clk;

    udp_rx_top u_udp_rx_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .s_data    (s_data),
        .s_valid   (s_valid),
        .s_last    (s_last),
        .s_ready   (s_ready),
        .m_data    (m_data),
        .m_valid   (m_valid),
        .m_last    (m_last),
        .m_ready   (m_ready),
        .src_mac   (src_mac),
        .src_ip    (src_ip),
        .src_port  (src_port),
        .dest_port (dest_port)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_byte(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_mac(input string name, input logic [MAC_W-1:0] got,
                             input logic [MAC_W-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_ip(input string name, input logic [IP_W-1:0] got,
                            input logic [IP_W-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_port(input string name, input logic [PORT_W-1:0] got,
                              input logic [PORT_W-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    // Splits the tagged words into input bytes and expected frames
    task automatic load_vectors();
        logic [11:0]       word;
        logic [MAC_W-1:0]  mac;
        logic [IP_W-1:0]   ip;
        logic [PORT_W-1:0] sport;
        logic [PORT_W-1:0] dport;
        int                idx;
        logic              at_end;
        mac    = '0;
        ip     = '0;
        sport  = '0;
        dport  = '0;
        idx    = 0;
        at_end = 1'b0;
        $readmemh("test/udp_rx_vectors.txt", vec_mem);
        while (!at_end && idx < $size(vec_mem)) begin
            word = vec_mem[idx];
            if ($isunknown(word)) begin
                $display("Vector file ends without an end marker at word %0d", idx);
                frame_errors++;
                at_end = 1'b1;
            end else begin
                case (word[11:8])
                    4'h0, 4'h1: in_bytes.push_back({word[8], word[7:0]});
                    4'h4: mac = {mac[MAC_W-DATA_W-1:0], word[7:0]};
                    4'h5: ip = {ip[IP_W-DATA_W-1:0], word[7:0]};
                    4'h6: sport = {sport[PORT_W-DATA_W-1:0], word[7:0]};
                    4'h7: dport = {dport[PORT_W-DATA_W-1:0], word[7:0]};
                    4'h8: exp_pay.push_back({1'b0, word[7:0]});
                    4'h9: begin
                        exp_pay.push_back({1'b1, word[7:0]});
                        exp_mac.push_back(mac);
                        exp_ip.push_back(ip);
                        exp_sport.push_back(sport);
                        exp_dport.push_back(dport);
                    end
                    4'hf: at_end = 1'b1;
                    default: begin
                        $display("Unknown tag %h in vector word %0d", word[11:8], idx);
                        frame_errors++;
                    end
                endcase
            end
            idx++;
        end
        pay_total = exp_pay.size();
        if (in_bytes.size() == 0) begin
            $display("No input frames found in the vector file");
            frame_errors++;
        end
    endtask

    task automatic check_reset_state();
        check_bit("m_valid", m_valid, 1'b0);
        check_mac("src_mac", src_mac, '0);
        check_ip("src_ip", src_ip, '0);
        check_port("src_port", src_port, '0);
        check_port("dest_port", dest_port, '0);
    endtask

    // Sends every input byte, holding each one until it is accepted
    task automatic drive_frames();
        int pos;
        pos = 0;
        while (pos < in_bytes.size()) begin
            @(posedge clk);
            if (s_valid && s_ready) begin
                pos++;
            end
            if (!s_valid || s_ready) begin
                if (pos < in_bytes.size() && send_ok) begin
                    s_valid <= 1'b1;
                    s_data  <= in_bytes[pos][DATA_W-1:0];
                    s_last  <= in_bytes[pos][DATA_W];
                end else begin
                    s_valid <= 1'b0;
                end
            end
        end
    endtask

    // One random word per cycle sets m_ready and the input gaps
    always @(posedge clk) begin
        rng_state = xorshift(rng_state);
        m_ready <= (rng_state[1:0] != 2'b00);
        send_ok <= (rng_state[9:8] != 2'b00);
    end

    // Header fields are checked on every payload byte of a frame
    always @(posedge clk) begin
        if (rst_n && m_valid && m_ready) begin
            if (pay_pos >= pay_total) begin
                $display("Extra output byte %h after the last expected frame", m_data);
                frame_errors++;
            end else begin
                check_byte("m_data", m_data, exp_pay[pay_pos][DATA_W-1:0]);
                check_bit("m_last", m_last, exp_pay[pay_pos][DATA_W]);
                check_mac("src_mac", src_mac, exp_mac[frames_seen]);
                check_ip("src_ip", src_ip, exp_ip[frames_seen]);
                check_port("src_port", src_port, exp_sport[frames_seen]);
                check_port("dest_port", dest_port, exp_dport[frames_seen]);
                if (exp_pay[pay_pos][DATA_W]) begin
                    frames_seen++;
                end
                pay_pos++;
            end
        end
    end

    initial begin
        wait (vectors_ready);
        repeat (20 * in_bytes.size() + 200) @(posedge clk);
        $display("Timeout, only %0d of %0d expected frames arrived, %0d value errors",
                 frames_seen, exp_mac.size(), value_errors);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        rst_n   = 1'b0;
        s_data  = '0;
        s_valid = 1'b0;
        s_last  = 1'b0;
        m_ready = 1'b0;
        send_ok = 1'b0;
        load_vectors();
        vectors_ready = 1'b1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_reset_state();
        drive_frames();
        wait (pay_pos == pay_total);
        // Room for a stray byte after the final frame
        repeat (10) @(posedge clk);
        $display("Errors: %0d value mismatches, %0d frame errors", value_errors, frame_errors);
        if (value_errors == 0 && frame_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/udp_rx_top.sv
`default_nettype none

// UDP receive path with the Ethernet, IPv4 and UDP header parsers in a chain
module udp_rx_top
    import udp_rx_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    input  wire  [DATA_W-1:0] s_data,
    input  wire               s_valid,
    input  wire               s_last,
    output wire               s_ready,
    output wire  [DATA_W-1:0] m_data,
    output wire               m_valid,
    output wire               m_last,
    input  wire               m_ready,
    output wire  [MAC_W-1:0]  src_mac,
    output wire  [IP_W-1:0]   src_ip,
    output wire  [PORT_W-1:0] src_port,
    output wire  [PORT_W-1:0] dest_port
);

    // Ethernet payload stream
    wire [DATA_W-1:0] eth_data;
    wire              eth_valid;
    wire              eth_ready;
    wire              eth_last;
    wire [MAC_W-1:0]  eth_src_mac;

    // IPv4 payload stream
    wire [DATA_W-1:0] ip_data;
    wire              ip_valid;
    wire              ip_ready;
    wire              ip_last;
    wire [MAC_W-1:0]  ip_src_mac;
    wire [IP_W-1:0]   ip_src_ip;

    eth_hdr_rx u_eth_hdr_rx (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_data  (s_data),
        .s_valid (s_valid),
        .s_last  (s_last),
        .s_ready (s_ready),
        .m_data  (eth_data),
        .m_valid (eth_valid),
        .m_last  (eth_last),
        .m_ready (eth_ready),
        .src_mac (eth_src_mac)
    );

    ip_hdr_rx u_ip_hdr_rx (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_data  (eth_data),
        .s_valid (eth_valid),
        .s_last  (eth_last),
        .s_ready (eth_ready),
        .in_mac  (eth_src_mac),
        .m_data  (ip_data),
        .m_valid (ip_valid),
        .m_last  (ip_last),
        .m_ready (ip_ready),
        .src_mac (ip_src_mac),
        .src_ip  (ip_src_ip)
    );

    udp_hdr_rx u_udp_hdr_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .s_data    (ip_data),
        .s_valid   (ip_valid),
        .s_last    (ip_last),
        .s_ready   (ip_ready),
        .in_mac    (ip_src_mac),
        .in_ip     (ip_src_ip),
        .m_data    (m_data),
        .m_valid   (m_valid),
        .m_last    (m_last),
        .m_ready   (m_ready),
        .src_mac   (src_mac),
        .src_ip    (src_ip),
        .src_port  (src_port),
        .dest_port (dest_port)
    );

endmodule

`default_nettype wire

// File: hw/udp_hdr_rx.sv
`default_nettype none

// Strips the UDP header and presents the ports with the payload
module udp_hdr_rx
    import udp_rx_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    input  wire  [DATA_W-1:0] s_data,
    input  wire               s_valid,
    input  wire               s_last,
    output logic              s_ready,
    input  wire  [MAC_W-1:0]  in_mac,
    input  wire  [IP_W-1:0]   in_ip,
    output logic [DATA_W-1:0] m_data,
    output logic              m_valid,
    output logic              m_last,
    input  wire               m_ready,
    output logic [MAC_W-1:0]  src_mac,
    output logic [IP_W-1:0]   src_ip,
    output logic [PORT_W-1:0] src_port,
    output logic [PORT_W-1:0] dest_port
);

    logic [$clog2(UDP_HDR_BYTES+1)-1:0] hdr_cnt;
    logic hdr_phase;
    logic out_free;
    logic accept;
    logic load;

    assign hdr_phase = (hdr_cnt != UDP_HDR_BYTES);
    assign out_free  = !m_valid || m_ready;
    assign s_ready   = (hdr_phase && hdr_cnt != '0) || out_free;
    assign accept    = s_valid && s_ready;
    assign load      = accept && !hdr_phase;

    // Last on header byte 7 or earlier leaves nothing to forward
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdr_cnt <= '0;
        end else if (accept) begin
            if (s_last) begin
                hdr_cnt <= '0;
            end else if (hdr_phase) begin
                hdr_cnt <= hdr_cnt + 1'b1;
            end
        end
    end

    // Upstream fields latch at header start and the ports come from bytes 0 to 3
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_mac   <= '0;
            src_ip    <= '0;
            src_port  <= '0;
            dest_port <= '0;
        end else if (accept) begin
            if (hdr_cnt == 0) begin
                src_mac <= in_mac;
                src_ip  <= in_ip;
            end
            if (hdr_cnt <= 1) begin
                src_port <= {src_port[PORT_W-DATA_W-1:0], s_data};
            end else if (hdr_cnt <= 3) begin
                dest_port <= {dest_port[PORT_W-DATA_W-1:0], s_data};
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
            m_last  <= 1'b0;
        end else if (load) begin
            m_valid <= 1'b1;
            m_last  <= s_last;
        end else if (m_ready) begin
            m_valid <= 1'b0;
            m_last  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            m_data <= s_data;
        end
    end

    a_last_valid: assert property (@(posedge clk) disable iff (!rst_n)
        m_last |-> m_valid);

endmodule

`default_nettype wire

// File: hw/ip_hdr_rx.sv
`default_nettype none

// Strips the IPv4 header and accepts version 4 without options carrying UDP
module ip_hdr_rx
    import udp_rx_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    input  wire  [DATA_W-1:0] s_data,
    input  wire               s_valid,
    input  wire               s_last,
    output logic              s_ready,
    input  wire  [MAC_W-1:0]  in_mac,
    output logic [DATA_W-1:0] m_data,
    output logic              m_valid,
    output logic              m_last,
    input  wire               m_ready,
    output logic [MAC_W-1:0]  src_mac,
    output logic [IP_W-1:0]   src_ip
);

    logic [$clog2(IP_HDR_BYTES+1)-1:0] hdr_cnt;
    logic hdr_bad;
    logic hdr_phase;
    logic out_free;
    logic accept;
    logic load;

    assign hdr_phase = (hdr_cnt != IP_HDR_BYTES);
    assign out_free  = !m_valid || m_ready;

    // A rejected header turns the payload into a sink
    always_comb begin
        if (hdr_phase) begin
            s_ready = (hdr_cnt != '0) || out_free;
        end else begin
            s_ready = hdr_bad || out_free;
        end
    end

    assign accept = s_valid && s_ready;
    assign load   = accept && !hdr_phase && !hdr_bad;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdr_cnt <= '0;
        end else if (accept) begin
            if (s_last) begin
                hdr_cnt <= '0;
            end else if (hdr_phase) begin
                hdr_cnt <= hdr_cnt + 1'b1;
            end
        end
    end

    // Version and IHL in byte 0 and the protocol in byte 9
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdr_bad <= 1'b0;
        end else if (accept && hdr_cnt == 0) begin
            hdr_bad <= (s_data[7:4] != IP_VERSION_4) || (s_data[3:0] != IP_IHL_NO_OPT);
        end else if (accept && hdr_cnt == 9 && s_data != IP_PROTO_UDP) begin
            hdr_bad <= 1'b1;
        end
    end

    // MAC from the Ethernet stage is stable once its payload starts
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_mac <= '0;
        end else if (accept && hdr_cnt == 0) begin
            src_mac <= in_mac;
        end
    end

    // Source address in bytes 12 to 15
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_ip <= '0;
        end else if (accept && hdr_cnt >= 12 && hdr_cnt <= 15) begin
            src_ip <= {src_ip[IP_W-DATA_W-1:0], s_data};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
            m_last  <= 1'b0;
        end else if (load) begin
            m_valid <= 1'b1;
            m_last  <= s_last;
        end else if (m_ready) begin
            m_valid <= 1'b0;
            m_last  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            m_data <= s_data;
        end
    end

    a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
        hdr_cnt <= IP_HDR_BYTES);

endmodule

`default_nettype wire

// File: hw/eth_hdr_rx.sv
`default_nettype none

// Strips the Ethernet header and passes IPv4 frames only
module eth_hdr_rx
    import udp_rx_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    input  wire  [DATA_W-1:0] s_data,
    input  wire               s_valid,
    input  wire               s_last,
    output logic              s_ready,
    output logic [DATA_W-1:0] m_data,
    output logic              m_valid,
    output logic              m_last,
    input  wire               m_ready,
    output logic [MAC_W-1:0]  src_mac
);

    // Header byte count that rests at ETH_HDR_BYTES in the payload
    logic [$clog2(ETH_HDR_BYTES+1)-1:0] hdr_cnt;
    logic [15:0] eth_type;
    logic        hdr_phase;
    logic        pass;
    logic        out_free;
    logic        accept;
    logic        load;

    assign hdr_phase = (hdr_cnt != ETH_HDR_BYTES);
    assign pass      = (eth_type == ETHERTYPE_IPV4);
    assign out_free  = !m_valid || m_ready;

    // First header byte waits until the previous frame has left the output
    always_comb begin
        if (hdr_phase) begin
            s_ready = (hdr_cnt != '0) || out_free;
        end else begin
            s_ready = !pass || out_free;
        end
    end

    assign accept = s_valid && s_ready;
    assign load   = accept && !hdr_phase && pass;

    // A last byte ends the frame even inside the header
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdr_cnt <= '0;
        end else if (accept) begin
            if (s_last) begin
                hdr_cnt <= '0;
            end else if (hdr_phase) begin
                hdr_cnt <= hdr_cnt + 1'b1;
            end
        end
    end

    // Source MAC sits in bytes 6 to 11
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_mac <= '0;
        end else if (accept && hdr_cnt >= 6 && hdr_cnt <= 11) begin
            src_mac <= {src_mac[MAC_W-DATA_W-1:0], s_data};
        end
    end

    // EtherType sits in bytes 12 and 13
    always_ff @(posedge clk) begin
        if (accept && hdr_phase && hdr_cnt >= 12) begin
            eth_type <= {eth_type[7:0], s_data};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
            m_last  <= 1'b0;
        end else if (load) begin
            m_valid <= 1'b1;
            m_last  <= s_last;
        end else if (m_ready) begin
            m_valid <= 1'b0;
            m_last  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            m_data <= s_data;
        end
    end

    // Output byte holds until the next stage takes it
    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule

`default_nettype wire

// File: common/udp_rx_pkg.sv
`default_nettype none

// Widths and protocol constants for the UDP receive path
package udp_rx_pkg;

    // Stream and header field widths
    localparam int unsigned DATA_W = 8;
    localparam int unsigned MAC_W  = 48;
    localparam int unsigned IP_W   = 32;
    localparam int unsigned PORT_W = 16;

    // Header lengths in bytes
    localparam int unsigned ETH_HDR_BYTES = 14;
    // IPv4 without options only
    localparam int unsigned IP_HDR_BYTES  = 20;
    localparam int unsigned UDP_HDR_BYTES = 8;

    // Accepted EtherType
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;

    // First IPv4 header byte holds version and IHL
    localparam logic [3:0] IP_VERSION_4  = 4'd4;
    localparam logic [3:0] IP_IHL_NO_OPT = 4'd5;

    // Protocol field value for UDP
    localparam logic [7:0] IP_PROTO_UDP = 8'd17;

endpackage

`default_nettype wire
